/* cpu_bus_pkg.sv */
`default_nettype none

package cpu_bus_pkg;

    localparam int word_w = 32;
    localparam int lanes  = 4;

    // one bit per byte lane of a data word
    typedef logic [lanes-1:0] byte_en_t;

    typedef logic [$clog2(lanes)-1:0] lane_t;

    // text memory holds one character per byte
    typedef logic [7:0] char_t;

endpackage

`default_nettype wire

/* files.f */
mem_map_pkg.sv
cpu_bus_pkg.sv
region_decoder.sv
text_write_fsm.sv
wait_counter.sv
text_mem.sv
loader_mem.sv
mmio_top.sv
tb_mmio_top.sv

/* loader_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module loader_mem #(
    parameter int loader_addr_w = 13
) (
    input  wire                            text_mem_clk,
    input  wire cpu_bus_pkg::byte_en_t     loader_wen,
    input  wire [mem_map_pkg::addr_w-1:0]  dmem_addr,
    input  wire [cpu_bus_pkg::word_w-1:0]  wr_data,
    input  wire [mem_map_pkg::addr_w-1:0]  instr_addr,
    output logic [cpu_bus_pkg::word_w-1:0] loader_data,
    output logic [cpu_bus_pkg::word_w-1:0] loader_instr
);

    import cpu_bus_pkg::*;

    logic [word_w-1:0]        words [2**loader_addr_w];
    logic [loader_addr_w-1:0] d_idx;
    logic [loader_addr_w-1:0] i_idx;

    // upper address bits alias onto the same words
    assign d_idx = dmem_addr[loader_addr_w-1:0];
    assign i_idx = instr_addr[loader_addr_w-1:0];

    // data port, byte lane writes
    always_ff @(posedge text_mem_clk) begin
        for (int i = 0; i < lanes; i++) begin
            if (loader_wen[i]) begin
                words[d_idx][i*8 +: 8] <= wr_data[i*8 +: 8];
            end
        end
        loader_data <= words[d_idx];
    end

    // instruction port is read only
    always_ff @(posedge text_mem_clk) begin
        loader_instr <= words[i_idx];
    end

endmodule

`default_nettype wire

/* mem_map_pkg.sv */
`default_nettype none

package mem_map_pkg;

    // cpu word address, byte offset already stripped
    localparam int addr_w = 30;

    typedef logic [3:0] region_t;

    localparam region_t region_vmem   = 4'hc;
    localparam region_t region_trap   = 4'hd;
    localparam region_t region_kbd    = 4'he;
    localparam region_t region_loader = 4'hf;

    // selector in bits 25:18 that traps inside the 0xd region
    localparam logic [7:0] trap_sel = 8'hdd;

    typedef struct packed {
        region_t     region;
        logic [7:0]  sel;
        logic [17:0] rest;
    } mmio_view_t;

    typedef struct packed {
        region_t     region;
        logic [12:0] unused;
        logic [12:0] index;
    } text_view_t;

    // one address word, decoded by region or by text word index
    typedef union packed {
        mmio_view_t mmio;
        text_view_t text;
    } word_addr_u;

endpackage

`default_nettype wire

/* mmio_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mmio_top #(
    parameter int wait_cycles   = 2,
    parameter int text_addr_w   = 15,
    parameter int loader_addr_w = 13
) (
    input  wire                            text_mem_clk,
    input  wire                            rst,
    input  wire mem_map_pkg::word_addr_u   instr_addr,
    input  wire mem_map_pkg::word_addr_u   dmem_addr,
    input  wire                            dmem_read,
    input  wire                            dmem_write,
    input  wire [cpu_bus_pkg::word_w-1:0]  wr_data,
    input  wire cpu_bus_pkg::byte_en_t     byte_en,
    output logic [cpu_bus_pkg::word_w-1:0] instr_data,
    output logic [cpu_bus_pkg::word_w-1:0] rd_data,
    output logic                           mem_stall,
    output logic                           ext_read,
    output logic                           ext_write,
    output logic                           ext_instr_read,
    input  wire [cpu_bus_pkg::word_w-1:0]  ext_rd_data,
    input  wire [cpu_bus_pkg::word_w-1:0]  ext_instr_data,
    input  wire                            ext_stall,
    input  wire cpu_bus_pkg::char_t        kb_keycode,
    input  wire                            kb_ready,
    output logic                           kb_read,
    input  wire [text_addr_w-1:0]          text_rd_addr,
    output cpu_bus_pkg::char_t             text_rd_char
);

    import cpu_bus_pkg::*;

    byte_en_t          loader_wen;
    logic [word_w-1:0] loader_data;
    logic [word_w-1:0] loader_instr;
    logic              vmem_req;
    logic              vmem_stall;
    logic              trap_stall;
    logic              kb_stall;
    logic              text_wen;
    logic              count_en;
    logic              done;

    assign mem_stall = ext_stall | vmem_stall | trap_stall | kb_stall;

    region_decoder #(
        .loader_addr_w (loader_addr_w)
    ) u_region_decoder (
        .text_mem_clk   (text_mem_clk),
        .rst            (rst),
        .instr_addr     (instr_addr),
        .dmem_addr      (dmem_addr),
        .dmem_read      (dmem_read),
        .dmem_write     (dmem_write),
        .byte_en        (byte_en),
        .kb_keycode     (kb_keycode),
        .kb_ready       (kb_ready),
        .loader_data    (loader_data),
        .loader_instr   (loader_instr),
        .ext_rd_data    (ext_rd_data),
        .ext_instr_data (ext_instr_data),
        .rd_data        (rd_data),
        .instr_data     (instr_data),
        .ext_read       (ext_read),
        .ext_write      (ext_write),
        .ext_instr_read (ext_instr_read),
        .kb_read        (kb_read),
        .vmem_req       (vmem_req),
        .loader_wen     (loader_wen),
        .trap_stall     (trap_stall),
        .kb_stall       (kb_stall)
    );

    //////////////////////////////////////////////////
    // text memory write sequencing
    //////////////////////////////////////////////////
    text_write_fsm #(
        .wait_cycles (wait_cycles)
    ) u_text_write_fsm (
        .text_mem_clk (text_mem_clk),
        .rst          (rst),
        .vmem_req     (vmem_req),
        .done         (done),
        .text_wen     (text_wen),
        .vmem_stall   (vmem_stall),
        .count_en     (count_en)
    );

    wait_counter #(
        .wait_cycles (wait_cycles)
    ) u_wait_counter (
        .text_mem_clk (text_mem_clk),
        .rst          (rst),
        .count_en     (count_en),
        .done         (done)
    );

    text_mem #(
        .text_addr_w (text_addr_w)
    ) u_text_mem (
        .text_mem_clk (text_mem_clk),
        .rst          (rst),
        .text_wen     (text_wen),
        .dmem_addr    (dmem_addr),
        .byte_en      (byte_en),
        .wr_data      (wr_data),
        .text_rd_addr (text_rd_addr),
        .text_rd_char (text_rd_char)
    );

    loader_mem #(
        .loader_addr_w (loader_addr_w)
    ) u_loader_mem (
        .text_mem_clk (text_mem_clk),
        .loader_wen   (loader_wen),
        .dmem_addr    (dmem_addr),
        .wr_data      (wr_data),
        .instr_addr   (instr_addr),
        .loader_data  (loader_data),
        .loader_instr (loader_instr)
    );

endmodule

`default_nettype wire

/* region_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module region_decoder #(
    parameter int loader_addr_w = 13
) (
    input  wire                            text_mem_clk,
    input  wire                            rst,
    input  wire mem_map_pkg::word_addr_u   instr_addr,
    input  wire mem_map_pkg::word_addr_u   dmem_addr,
    input  wire                            dmem_read,
    input  wire                            dmem_write,
    input  wire cpu_bus_pkg::byte_en_t     byte_en,
    input  wire cpu_bus_pkg::char_t        kb_keycode,
    input  wire                            kb_ready,
    input  wire [cpu_bus_pkg::word_w-1:0]  loader_data,
    input  wire [cpu_bus_pkg::word_w-1:0]  loader_instr,
    input  wire [cpu_bus_pkg::word_w-1:0]  ext_rd_data,
    input  wire [cpu_bus_pkg::word_w-1:0]  ext_instr_data,
    output logic [cpu_bus_pkg::word_w-1:0] rd_data,
    output logic [cpu_bus_pkg::word_w-1:0] instr_data,
    output logic                           ext_read,
    output logic                           ext_write,
    output logic                           ext_instr_read,
    output logic                           kb_read,
    output logic                           vmem_req,
    output cpu_bus_pkg::byte_en_t          loader_wen,
    output logic                           trap_stall,
    output logic                           kb_stall
);

    import mem_map_pkg::*;
    import cpu_bus_pkg::*;

    region_t d_region;
    logic    is_main;
    logic    is_loader;
    logic    fetch_loader;
    logic    loader_rd_q;

    assign d_region     = dmem_addr.mmio.region;
    assign is_loader    = (d_region == region_loader);
    assign is_main      = !(d_region inside {region_vmem, region_trap, region_kbd, region_loader});
    assign fetch_loader = (instr_addr.mmio.region == region_loader);

    //////////////////////////////////////////////////
    // data side strobes
    //////////////////////////////////////////////////
    assign ext_read   = is_main && dmem_read;
    assign ext_write  = is_main && dmem_write;
    assign vmem_req   = (d_region == region_vmem) && dmem_write;
    // only selector 0xdd traps, rest of 0xd reads as zero
    assign trap_stall = (d_region == region_trap) && (dmem_addr.mmio.sel == trap_sel)
                        && (dmem_read || dmem_write);
    assign kb_read    = (d_region == region_kbd) && dmem_read;
    assign kb_stall   = kb_read && !kb_ready;

    // loader lanes are mirrored against the cpu byte enable
    always_comb begin
        loader_wen = '0;
        if (is_loader && dmem_write) begin
            case (byte_en)
                4'b0001: loader_wen = 4'b1000;
                4'b0010: loader_wen = 4'b0100;
                4'b0100: loader_wen = 4'b0010;
                4'b1000: loader_wen = 4'b0001;
                default: loader_wen = '1;
            endcase
        end
    end

    always_comb begin
        case (d_region)
            region_vmem, region_trap: rd_data = '0;
            region_kbd:    rd_data = {{(word_w - $bits(char_t)){1'b0}}, kb_keycode};
            region_loader: rd_data = loader_data;
            default:       rd_data = ext_rd_data;
        endcase
        // loader word stays visible for the cycle after its read
        if (loader_rd_q && !dmem_read) begin
            rd_data = loader_data;
        end
    end

    always_ff @(posedge text_mem_clk) begin
        if (!rst) begin
            loader_rd_q <= 1'b0;
        end else begin
            loader_rd_q <= is_loader && dmem_read;
        end
    end

    //////////////////////////////////////////////////
    // instruction fetch redirect
    //////////////////////////////////////////////////
    assign ext_instr_read = !fetch_loader;
    assign instr_data     = fetch_loader ? loader_instr : ext_instr_data;

    a_one_region: assert property (@(posedge text_mem_clk) disable iff (!rst)
        $onehot0({ext_read || ext_write, vmem_req, trap_stall, kb_read, |loader_wen}));

    // loader memory only sees the low index bits, upper offset must stay clear
    a_loader_range: assert property (@(posedge text_mem_clk) disable iff (!rst)
        (|loader_wen) |-> (dmem_addr[addr_w-$bits(region_t)-1:loader_addr_w] == '0));

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mmio_top -f files.f -o sim_mmio

out=$(./obj_dir/sim_mmio 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "test passed"; then
    exit 0
else
    exit 1
fi

/* tb_mmio_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mmio_top;

    // limit keeps a wide margin over about 700 cycles of stimulus
    localparam int max_cycles = 3000;

    logic        text_mem_clk;
    logic        rst;
    logic [29:0] instr_addr;
    logic [29:0] dmem_addr;
    logic        dmem_read;
    logic        dmem_write;
    logic [31:0] wr_data;
    logic [3:0]  byte_en;
    logic [31:0] instr_data;
    logic [31:0] rd_data;
    logic        mem_stall;
    logic        ext_read;
    logic        ext_write;
    logic        ext_instr_read;
    logic [31:0] ext_rd_data;
    logic [31:0] ext_instr_data;
    logic        ext_stall;
    logic [7:0]  kb_keycode;
    logic        kb_ready;
    logic        kb_read;
    logic [14:0] text_rd_addr;
    logic [7:0]  text_rd_char;

    // check enables driven together with the stimulus
    logic        chk_idle;
    logic        chk_main;
    logic        vmem_start;
    logic        disp_chk;
    logic        ld_chk;
    logic        kb_chk;
    logic        trap_chk;
    logic        zero_chk;
    logic [7:0]  disp_exp;
    logic [31:0] ld_exp;

    logic [7:0]  text_ref [32768];
    logic [14:0] text_addrs [$];
    logic [31:0] loader_ref [8192];
    logic [12:0] ld_idx [8];
    int          cycles = 0;

    mmio_top u_dut (.*);

    initial begin
        text_mem_clk = 1'b0;
        forever #5 text_mem_clk = ~text_mem_clk;
    end

    task automatic fail_now(input string line);
        $display("%s", line);
        $display("test failed");
        $fatal(1);
    endtask

    always @(posedge text_mem_clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            fail_now($sformatf("timeout: test did not finish within %0d cycles", max_cycles));
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////
    a_idle: assert property (@(posedge text_mem_clk) disable iff (!rst)
        chk_idle |-> !mem_stall && !ext_read && !ext_write && !kb_read && ext_instr_read)
    else fail_now($sformatf("FAILED %0t: strobe or stall active while idle", $time));

    a_main_strobes: assert property (@(posedge text_mem_clk) disable iff (!rst)
        chk_main |-> ext_read == dmem_read && ext_write == dmem_write && mem_stall == ext_stall)
    else fail_now($sformatf("FAILED %0t: main memory strobes or stall wrong", $time));

    a_main_data: assert property (@(posedge text_mem_clk) disable iff (!rst)
        chk_main |-> rd_data == ext_rd_data && instr_data == ext_instr_data && ext_instr_read)
    else fail_now($sformatf("FAILED %0t: main memory read or fetch data wrong", $time));

    // vmem write stalls wait_cycles + 1 cycles and then releases while held
    a_vmem_stall: assert property (@(posedge text_mem_clk) disable iff (!rst)
        vmem_start |-> mem_stall ##1 mem_stall ##1 mem_stall ##1 !mem_stall)
    else fail_now($sformatf("FAILED %0t: vmem write stall length wrong", $time));

    a_display: assert property (@(posedge text_mem_clk) disable iff (!rst)
        disp_chk |=> text_rd_char == $past(disp_exp))
    else fail_now($sformatf("FAILED %0t: display read returned %h", $time, text_rd_char));

    a_loader: assert property (@(posedge text_mem_clk) disable iff (!rst)
        ld_chk |=> rd_data == $past(ld_exp) && instr_data == $past(ld_exp) && !ext_instr_read)
    else fail_now($sformatf("FAILED %0t: loader read %h fetch %h", $time, rd_data, instr_data));

    a_keyboard: assert property (@(posedge text_mem_clk) disable iff (!rst)
        kb_chk |-> kb_read && rd_data == 32'(kb_keycode) && mem_stall == !kb_ready)
    else fail_now($sformatf("FAILED %0t: keyboard read or stall wrong", $time));

    a_trap: assert property (@(posedge text_mem_clk) disable iff (!rst)
        trap_chk |-> mem_stall && rd_data == 32'd0)
    else fail_now($sformatf("FAILED %0t: trap access did not stall", $time));

    a_zero: assert property (@(posedge text_mem_clk) disable iff (!rst)
        zero_chk |-> !mem_stall && rd_data == 32'd0)
    else fail_now($sformatf("FAILED %0t: 0xd region read not zero or stalled", $time));

    //////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////
    // lane 0 sits at the top enable bit and the low data byte
    function automatic logic [1:0] lane_of(input logic [3:0] be);
        case (be)
            4'b1000: return 2'd0;
            4'b0100: return 2'd1;
            4'b0010: return 2'd2;
            default: return 2'd3;
        endcase
    endfunction

    task automatic drive_idle();
        instr_addr     = '0;
        dmem_addr      = '0;
        dmem_read      = 1'b0;
        dmem_write     = 1'b0;
        wr_data        = '0;
        byte_en        = '0;
        ext_rd_data    = '0;
        ext_instr_data = '0;
        ext_stall      = 1'b0;
        kb_keycode     = '0;
        kb_ready       = 1'b0;
        chk_idle       = 1'b0;
        chk_main       = 1'b0;
        vmem_start     = 1'b0;
        disp_chk       = 1'b0;
        ld_chk         = 1'b0;
        kb_chk         = 1'b0;
        trap_chk       = 1'b0;
        zero_chk       = 1'b0;
    endtask

    task automatic run_main(input int n);
        logic [1:0] op;
        for (int i = 0; i < n; i++) begin
            @(negedge text_mem_clk);
            chk_main = 1'b1;
            // cpu side holds while stalled
            if (!mem_stall) begin
                op         = 2'($urandom_range(0, 2));
                dmem_addr  = {4'($urandom_range(0, 11)), 26'($urandom)};
                instr_addr = {4'($urandom_range(0, 14)), 26'($urandom)};
                dmem_read  = (op == 2'd1);
                dmem_write = (op == 2'd2);
                wr_data    = $urandom;
                byte_en    = 4'($urandom);
            end
            ext_rd_data    = $urandom;
            ext_instr_data = $urandom;
            ext_stall      = ($urandom_range(0, 3) == 0);
        end
        @(negedge text_mem_clk);
        drive_idle();
    endtask

    task automatic write_text_char();
        logic [12:0] index;
        logic [3:0]  be;
        logic [31:0] data;
        logic [14:0] addr;
        index = 13'($urandom);
        be    = 4'($urandom);
        data  = $urandom;
        addr  = {index, lane_of(be)};
        @(negedge text_mem_clk);
        dmem_addr  = {4'hc, 13'($urandom), index};
        dmem_write = 1'b1;
        byte_en    = be;
        wr_data    = data;
        vmem_start = 1'b1;
        @(negedge text_mem_clk);
        vmem_start = 1'b0;
        while (mem_stall) begin
            @(negedge text_mem_clk);
        end
        // one cycle in hold with the write still presented
        @(negedge text_mem_clk);
        drive_idle();
        text_ref[addr] = 8'(data >> (8 * lane_of(be)));
        text_addrs.push_back(addr);
        text_rd_addr = addr;
        disp_exp     = text_ref[addr];
        disp_chk     = 1'b1;
        @(negedge text_mem_clk);
        disp_chk = 1'b0;
    endtask

    // a single enable lands on the mirrored lane and anything else on all lanes
    task automatic write_loader(input logic [12:0] idx, input logic [3:0] be,
                                input logic [31:0] data);
        logic [3:0] lanes;
        lanes = $onehot(be) ? {be[0], be[1], be[2], be[3]} : 4'b1111;
        @(negedge text_mem_clk);
        dmem_addr  = {4'hf, 13'd0, idx};
        dmem_write = 1'b1;
        dmem_read  = 1'b0;
        byte_en    = be;
        wr_data    = data;
        for (int i = 0; i < 4; i++) begin
            if (lanes[i]) begin
                loader_ref[idx][i*8 +: 8] = data[i*8 +: 8];
            end
        end
    endtask

    task automatic read_loader(input logic [12:0] idx);
        @(negedge text_mem_clk);
        dmem_addr  = {4'hf, 13'd0, idx};
        instr_addr = {4'hf, 13'd0, idx};
        dmem_read  = 1'b1;
        dmem_write = 1'b0;
        ld_exp     = loader_ref[idx];
        ld_chk     = 1'b1;
        @(negedge text_mem_clk);
        // data side moves to main memory while the loader word comes back
        dmem_addr   = '0;
        ext_rd_data = ~loader_ref[idx];
        dmem_read   = 1'b0;
        ld_chk      = 1'b0;
        @(negedge text_mem_clk);
        drive_idle();
    endtask

    task automatic read_keyboard();
        int wait_n;
        wait_n = $urandom_range(1, 6);
        @(negedge text_mem_clk);
        dmem_addr  = {4'he, 26'($urandom)};
        dmem_read  = 1'b1;
        kb_keycode = 8'($urandom);
        kb_ready   = 1'b0;
        kb_chk     = 1'b1;
        repeat (wait_n) @(negedge text_mem_clk);
        kb_ready = 1'b1;
        @(negedge text_mem_clk);
        drive_idle();
    endtask

    task automatic access_trap();
        int hold_n;
        hold_n = $urandom_range(1, 6);
        @(negedge text_mem_clk);
        dmem_addr  = {4'hd, 8'hdd, 18'($urandom)};
        dmem_read  = ($urandom_range(0, 1) == 0);
        dmem_write = !dmem_read;
        trap_chk   = 1'b1;
        repeat (hold_n) @(negedge text_mem_clk);
        drive_idle();
    endtask

    task automatic read_zero();
        logic [7:0] sel;
        sel = 8'($urandom);
        if (sel == 8'hdd) begin
            sel = 8'hdc;
        end
        @(negedge text_mem_clk);
        dmem_addr = {4'hd, sel, 18'($urandom)};
        dmem_read = 1'b1;
        zero_chk  = 1'b1;
        @(negedge text_mem_clk);
        drive_idle();
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////
    initial begin
        void'($urandom(32'hb64b1cb9));
        rst          = 1'b0;
        text_rd_addr = '0;
        disp_exp     = '0;
        ld_exp       = '0;
        drive_idle();
        repeat (4) @(negedge text_mem_clk);
        rst      = 1'b1;
        chk_idle = 1'b1;
        repeat (4) @(negedge text_mem_clk);
        chk_idle = 1'b0;

        run_main(200);

        repeat (20) write_text_char();
        // every written character is still there
        foreach (text_addrs[i]) begin
            @(negedge text_mem_clk);
            text_rd_addr = text_addrs[i];
            disp_exp     = text_ref[text_addrs[i]];
            disp_chk     = 1'b1;
        end
        @(negedge text_mem_clk);
        disp_chk = 1'b0;

        // full word first so that later lane writes hit known bytes
        for (int i = 0; i < 8; i++) begin
            ld_idx[i] = 13'($urandom);
            write_loader(ld_idx[i], 4'b1111, $urandom);
        end
        repeat (24) write_loader(ld_idx[$urandom_range(0, 7)], 4'($urandom), $urandom);
        foreach (ld_idx[i]) begin
            read_loader(ld_idx[i]);
        end

        repeat (5) read_keyboard();
        repeat (4) access_trap();
        repeat (4) read_zero();
        repeat (2) @(negedge text_mem_clk);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* text_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module text_mem #(
    parameter int text_addr_w = 15
) (
    input  wire                           text_mem_clk,
    input  wire                           rst,
    input  wire                           text_wen,
    input  wire mem_map_pkg::word_addr_u  dmem_addr,
    input  wire cpu_bus_pkg::byte_en_t    byte_en,
    input  wire [cpu_bus_pkg::word_w-1:0] wr_data,
    input  wire [text_addr_w-1:0]         text_rd_addr,
    output cpu_bus_pkg::char_t            text_rd_char
);

    import cpu_bus_pkg::*;

    lane_t                  lane;
    char_t                  wr_char;
    logic [text_addr_w-1:0] wr_addr;
    char_t                  chars [2**text_addr_w];

    // lane 0 is the top enable bit but the low data byte
    always_comb begin
        case (byte_en)
            4'b1000: lane = 2'd0;
            4'b0100: lane = 2'd1;
            4'b0010: lane = 2'd2;
            default: lane = 2'd3;
        endcase
    end

    assign wr_char = wr_data[lane*8 +: 8];
    assign wr_addr = text_addr_w'({dmem_addr.text.index, lane});

    always_ff @(posedge text_mem_clk) begin
        if (text_wen) begin
            chars[wr_addr] <= wr_char;
        end
    end

    //////////////////////////////////////////////////
    // display read port
    //////////////////////////////////////////////////
    always_ff @(posedge text_mem_clk) begin
        if (!rst) begin
            text_rd_char <= '0;
        end else begin
            text_rd_char <= chars[text_rd_addr];
        end
    end

endmodule

`default_nettype wire

/* text_write_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module text_write_fsm #(
    parameter int wait_cycles = 2
) (
    input  wire  text_mem_clk,
    input  wire  rst,
    input  wire  vmem_req,
    input  wire  done,
    output logic text_wen,
    output logic vmem_stall,
    output logic count_en
);

    typedef enum logic [1:0] {
        st_idle,
        st_writing,
        st_hold
    } state_t;

    state_t state;
    state_t state_nxt;

    always_ff @(posedge text_mem_clk) begin
        if (!rst) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:    if (vmem_req) state_nxt = st_writing;
            st_writing: if (done) state_nxt = st_hold;
            // wait for the cpu to move off the vmem write
            st_hold:    if (!vmem_req) state_nxt = st_idle;
            default:    state_nxt = st_idle;
        endcase
    end

    // stall starts in the request cycle before the first write edge
    assign vmem_stall = (state == st_writing) || ((state == st_idle) && vmem_req);
    assign text_wen   = (state == st_writing);
    assign count_en   = (state == st_writing);

    // write only while the cpu still presents the vmem write
    a_wen_with_req: assert property (@(posedge text_mem_clk) disable iff (!rst)
        text_wen |-> (state != st_idle) && vmem_req);

    // writing lasts exactly wait_cycles and hold then releases the pipeline
    a_write_len: assert property (@(posedge text_mem_clk) disable iff (!rst)
        $rose(state == st_writing) |->
            (state == st_writing) [*wait_cycles] ##1 ((state == st_hold) && !vmem_stall));

endmodule

`default_nettype wire

/* wait_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module wait_counter #(
    parameter int wait_cycles = 2
) (
    input  wire  text_mem_clk,
    input  wire  rst,
    input  wire  count_en,
    output logic done
);

    localparam int cnt_w = $clog2(wait_cycles + 1);

    logic [cnt_w-1:0] cnt;

    always_ff @(posedge text_mem_clk) begin
        if (!rst || !count_en) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + cnt_w'(1);
        end
    end

    // high during the last of wait_cycles write cycles
    assign done = count_en && (cnt == cnt_w'(wait_cycles - 1));

endmodule

`default_nettype wire
